/* src/cpu_pkg.sv */
package cpu_pkg;

  localparam int addr_width = 10;

  typedef logic [15:0] word_t;
  typedef logic [addr_width-1:0] addr_t;

  localparam addr_t prog_base  = 10'h100;  // load and boot address
  localparam addr_t tx_addr    = 10'd1;    // store here goes out on the uart
  localparam word_t end_marker = 16'hffff;

  typedef enum logic [4:0] {
    op_add   = 5'd0,
    op_sub   = 5'd1,
    op_and   = 5'd2,
    op_dup   = 5'd3,
    op_load  = 5'd4,
    op_store = 5'd5,
    op_jmp   = 5'd6,
    op_jz    = 5'd7,
    op_halt  = 5'd8
  } opcode_e;

  // msb picks the view
  typedef union packed {
    struct packed {
      logic        is_push;  // set
      logic [14:0] imm;
    } push;
    struct packed {
      logic        is_push;  // clear
      opcode_e     opcode;
      addr_t       addr;
    } oper;
  } insn_t;

endpackage

/* src/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
  parameter int clks_per_bit = 234
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  localparam int cnt_w    = $clog2(2 * clks_per_bit);
  localparam int stop_cnt = clks_per_bit + clks_per_bit / 2 - 2;  // ends just before next start

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_start = 2'd1;
  localparam logic [1:0] st_data  = 2'd2;
  localparam logic [1:0] st_stop  = 2'd3;

  logic [1:0]       rx_sync;
  logic             rx_s;
  logic [1:0]       state;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shreg;
  logic             bit_tick;

  assign rx_s     = rx_sync[1];
  assign rx_byte  = shreg;
  assign bit_tick = (state == st_data) && (cnt == cnt_w'(clks_per_bit - 1));

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;  // idle line is high
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      cnt      <= '0;
      bit_idx  <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        st_idle: begin
          cnt <= '0;
          if (!rx_s) state <= st_start;
        end
        st_start: begin
          if (cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
            cnt     <= '0;
            bit_idx <= 3'd0;
            state   <= rx_s ? st_idle : st_data;  // glitch goes back to idle
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_data: begin
          if (bit_tick) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= st_stop;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (cnt == cnt_w'(stop_cnt)) begin
            state    <= st_idle;
            rx_valid <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (bit_tick) shreg <= {rx_s, shreg[7:1]};  // lsb first
  end

endmodule

/* src/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
  parameter int clks_per_bit = 234
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       tx_valid,
  input  logic [7:0] tx_byte,
  output logic       tx
);

  localparam int cnt_w = $clog2(clks_per_bit);

  logic             busy;
  logic [cnt_w-1:0] cnt;
  logic [3:0]       nbits;  // bits already put on the line after start
  logic [8:0]       shreg;  // stop bit above the data
  logic             bit_end;
  logic             accept;

  assign bit_end = busy && (cnt == cnt_w'(clks_per_bit - 1));
  assign accept  = !busy && tx_valid;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      cnt   <= '0;
      nbits <= 4'd0;
      tx    <= 1'b1;
    end else if (accept) begin
      busy  <= 1'b1;
      cnt   <= '0;
      nbits <= 4'd0;
      tx    <= 1'b0;  // start bit
    end else if (bit_end) begin
      cnt <= '0;
      if (nbits == 4'd9) begin
        busy <= 1'b0;  // stop bit done
      end else begin
        tx    <= shreg[0];
        nbits <= nbits + 1'b1;
      end
    end else if (busy) begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (accept) begin
      shreg <= {1'b1, tx_byte};
    end else if (bit_end) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

endmodule

/* src/program_loader.sv */
`timescale 1ns/10ps

module program_loader import cpu_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  output logic       load_we,
  output addr_t      load_addr,
  output word_t      load_data,
  output logic       run
);

  logic  phase;      // 0 waits for high byte, 1 for low byte
  logic  byte_in;
  logic  word_done;
  word_t next_word;

  assign byte_in   = rx_valid && !run;  // bytes after the marker are dropped
  assign word_done = byte_in && phase;
  assign next_word = {load_data[7:0], rx_byte};

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= 1'b0;
      load_we   <= 1'b0;
      load_addr <= prog_base;
      run       <= 1'b0;
    end else begin
      load_we <= word_done && (next_word != end_marker);
      if (byte_in) phase <= ~phase;
      if (word_done && next_word == end_marker) run <= 1'b1;
      if (load_we) load_addr <= load_addr + 1'b1;  // next word goes one higher
    end
  end

  // two-byte shift register, doubles as the write data
  always_ff @(posedge sys_clk) begin
    if (byte_in) load_data <= next_word;
  end

endmodule

/* src/program_mem.sv */
`timescale 1ns/10ps

module program_mem import cpu_pkg::*; (
  input  logic  sys_clk,
  input  logic  we,
  input  addr_t wr_addr,
  input  word_t wdata,
  input  addr_t rd_addr,
  output word_t rdata
);

  word_t mem [0:(1 << addr_width) - 1];

  always_ff @(posedge sys_clk) begin
    if (we) mem[wr_addr] <= wdata;
    rdata <= mem[rd_addr];  // one cycle read latency
  end

endmodule

/* src/stack_cpu.sv */
`timescale 1ns/10ps

module stack_cpu import cpu_pkg::*; #(
  parameter int stack_depth = 8
) (
  input  logic        sys_clk,
  input  logic        rst_n,
  input  logic        run,
  output addr_t       rd_addr,
  input  word_t       rdata,
  output logic        cpu_we,
  output addr_t       cpu_addr,
  output word_t       cpu_wdata,
  output logic        tx_valid,
  output logic [7:0]  tx_byte,
  output logic [47:0] stack_top
);

  localparam int sp_w  = $clog2(stack_depth + 1);
  localparam int idx_w = $clog2(stack_depth);

  localparam logic [1:0] st_fetch = 2'd0;
  localparam logic [1:0] st_exec  = 2'd1;  // decode and execute
  localparam logic [1:0] st_load  = 2'd2;
  localparam logic [1:0] st_halt  = 2'd3;

  logic [1:0]      state;
  addr_t           pc;
  logic [sp_w-1:0] sp;  // count of entries, also next free slot
  word_t           stk [stack_depth];

  insn_t            insn;
  logic             is_op;
  logic [idx_w-1:0] top_idx;
  logic [idx_w-1:0] sec_idx;
  logic [idx_w-1:0] push_idx;
  word_t            top;
  word_t            second;
  word_t            alu_out;

  logic             stk_we;
  logic [idx_w-1:0] stk_widx;
  word_t            stk_wdata;

  assign insn     = rdata;  // instruction word is valid in st_exec
  assign is_op    = (state == st_exec) && !insn.oper.is_push;
  assign top_idx  = idx_w'(sp - 1'b1);
  assign sec_idx  = idx_w'(sp - 2'd2);
  assign push_idx = idx_w'(sp);
  assign top      = stk[top_idx];
  assign second   = stk[sec_idx];

  // load address goes out while the instruction is on rdata
  assign rd_addr   = (state == st_exec) ? insn.oper.addr : pc;
  assign cpu_we    = is_op && (insn.oper.opcode == op_store);
  assign cpu_addr  = insn.oper.addr;
  assign cpu_wdata = top;

  always_comb begin
    case (insn.oper.opcode)
      op_add:  alu_out = second + top;
      op_sub:  alu_out = second - top;
      default: alu_out = second & top;
    endcase
  end

  always_comb begin
    stk_we    = 1'b0;
    stk_widx  = push_idx;
    stk_wdata = alu_out;
    if (state == st_load) begin
      stk_we    = 1'b1;
      stk_wdata = rdata;
    end else if (state == st_exec) begin
      if (insn.push.is_push) begin
        stk_we    = 1'b1;
        stk_wdata = word_t'(insn.push.imm);  // zero extend
      end else begin
        case (insn.oper.opcode)
          op_add, op_sub, op_and: begin
            stk_we   = 1'b1;
            stk_widx = sec_idx;  // result replaces second
          end
          op_dup: begin
            stk_we    = 1'b1;
            stk_wdata = top;
          end
          default: stk_we = 1'b0;
        endcase
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (stk_we) stk[stk_widx] <= stk_wdata;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_fetch;
      pc       <= prog_base;
      sp       <= '0;
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= cpu_we && (cpu_addr == tx_addr);
      if (!run) begin
        state <= st_fetch;  // held until the program is in
        pc    <= prog_base;
        sp    <= '0;
      end else begin
        case (state)
          st_fetch: state <= st_exec;
          st_load: begin
            sp    <= sp + 1'b1;
            state <= st_fetch;
          end
          st_exec: begin
            state <= st_fetch;
            pc    <= pc + 1'b1;
            if (insn.push.is_push) begin
              sp <= sp + 1'b1;
            end else begin
              case (insn.oper.opcode)
                op_add, op_sub, op_and, op_store: sp <= sp - 1'b1;
                op_dup:  sp <= sp + 1'b1;
                op_load: state <= st_load;
                op_jmp:  pc <= insn.oper.addr;
                op_jz: begin
                  sp <= sp - 1'b1;
                  if (top == '0) pc <= insn.oper.addr;
                end
                op_halt: state <= st_halt;
                default: ;  // unknown opcode runs as nop
              endcase
            end
          end
          default: state <= st_halt;  // stays halted
        endcase
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (cpu_we) tx_byte <= cpu_wdata[7:0];
  end

  // entry 0 is the top of stack, empty slots read as zero
  for (genvar i = 0; i < 6; i++) begin : g_top
    assign stack_top[8*i +: 8] =
      (sp > sp_w'(i)) ? stk[idx_w'(sp - sp_w'(i + 1))][7:0] : 8'h00;
  end

endmodule

/* src/led_matrix.sv */
`timescale 1ns/10ps

module led_matrix import cpu_pkg::*; #(
  parameter int scan_period = 27000,
  parameter int gap_on      = 100,
  parameter int gap_off     = 2000
) (
  input  logic        sys_clk,
  input  logic        rst_n,
  input  word_t       disp_word,
  input  addr_t       disp_addr,
  input  logic [47:0] stack_top,
  output logic [7:0]  led_col,
  output logic [8:0]  led_row
);

  localparam int cnt_w = $clog2(scan_period);

  logic [cnt_w-1:0] counter;
  logic [3:0]       row_idx;
  logic             row_on;

  // segments a..g in bits 7..1, dot in bit 0
  function automatic logic [7:0] seg7(input logic [4:0] n);
    logic [6:0] seg;
    case (n[3:0])
      4'h0: seg = 7'b1111110;
      4'h1: seg = 7'b0110000;
      4'h2: seg = 7'b1101101;
      4'h3: seg = 7'b1111001;
      4'h4: seg = 7'b0110011;
      4'h5: seg = 7'b1011011;
      4'h6: seg = 7'b1011111;
      4'h7: seg = 7'b1110010;
      4'h8: seg = 7'b1111111;
      4'h9: seg = 7'b1111011;
      4'ha: seg = 7'b1110111;
      4'hb: seg = 7'b0011111;
      4'hc: seg = 7'b1001110;
      4'hd: seg = 7'b0111101;
      4'he: seg = 7'b1001111;
      default: seg = 7'b1000111;  // f
    endcase
    return {seg, n[4]};
  endfunction

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      counter <= '0;
      row_idx <= 4'd0;
    end else if (counter == cnt_w'(scan_period - 1)) begin
      counter <= '0;
      row_idx <= (row_idx == 4'd8) ? 4'd0 : row_idx + 1'b1;
    end else begin
      counter <= counter + 1'b1;
    end
  end

  // dark gap at both row edges so neighbours do not ghost
  assign row_on  = (counter >= cnt_w'(gap_on)) && (counter < cnt_w'(scan_period - gap_off));
  assign led_row = row_on ? (9'b1 << row_idx) : 9'b0;

  always_comb begin
    case (row_idx)
      4'd0: led_col = disp_word[15:8];
      4'd1: led_col = disp_word[7:0];
      4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7: begin
        led_col = stack_top[8 * (row_idx - 4'd2) +: 8];  // top of stack on row 2
      end
      4'd8: led_col = seg7(disp_addr[4:0]);
      default: led_col = 8'h00;
    endcase
  end

endmodule

/* src/board_top.sv */
`timescale 1ns/10ps

module board_top import cpu_pkg::*; #(
  parameter int clks_per_bit = 234,
  parameter int stack_depth  = 8,
  parameter int scan_period  = 27000,
  parameter int gap_on       = 100,
  parameter int gap_off      = 2000
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       uart_rx,
  output logic       uart_tx,
  output logic [7:0] led_col,
  output logic [8:0] led_row
);

  logic [7:0]  rx_byte;
  logic        rx_valid;
  logic        load_we;
  addr_t       load_addr;
  word_t       load_data;
  logic        run;
  addr_t       rd_addr;
  word_t       rdata;
  logic        cpu_we;
  addr_t       cpu_addr;
  word_t       cpu_wdata;
  logic        tx_valid;
  logic [7:0]  tx_byte;
  logic [47:0] stack_top;
  logic        mem_we;
  addr_t       mem_addr;
  word_t       mem_wdata;
  word_t       disp_word;
  addr_t       disp_addr;

  // loader owns the write port until the end marker
  assign mem_we    = run ? cpu_we : load_we;
  assign mem_addr  = run ? cpu_addr : load_addr;
  assign mem_wdata = run ? cpu_wdata : load_data;

  always_ff @(posedge sys_clk) begin
    if (mem_we) begin
      disp_word <= mem_wdata;
      disp_addr <= mem_addr;
    end
  end

  uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
    .sys_clk(sys_clk), .rst_n(rst_n), .rx(uart_rx),
    .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  program_loader u_loader (
    .sys_clk(sys_clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .load_we(load_we), .load_addr(load_addr), .load_data(load_data), .run(run)
  );

  program_mem u_mem (
    .sys_clk(sys_clk), .we(mem_we), .wr_addr(mem_addr), .wdata(mem_wdata),
    .rd_addr(rd_addr), .rdata(rdata)
  );

  stack_cpu #(.stack_depth(stack_depth)) u_cpu (
    .sys_clk(sys_clk), .rst_n(rst_n), .run(run),
    .rd_addr(rd_addr), .rdata(rdata),
    .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .tx_valid(tx_valid), .tx_byte(tx_byte), .stack_top(stack_top)
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
    .sys_clk(sys_clk), .rst_n(rst_n), .tx_valid(tx_valid), .tx_byte(tx_byte),
    .tx(uart_tx)
  );

  led_matrix #(
    .scan_period(scan_period), .gap_on(gap_on), .gap_off(gap_off)
  ) u_leds (
    .sys_clk(sys_clk), .rst_n(rst_n), .disp_word(disp_word), .disp_addr(disp_addr),
    .stack_top(stack_top), .led_col(led_col), .led_row(led_row)
  );

endmodule

/* verification/board_tb.sv */
`timescale 1ns/10ps

module board_tb import cpu_pkg::*; ();

  localparam int clks_per_bit  = 8;
  localparam int byte_timeout  = 2000;  // cycles allowed for one uart frame
  localparam int row_timeout   = 2000;
  localparam int quiet_window  = 400;
  localparam int countdown_pad = 40;    // keeps stores one frame apart

  logic       sys_clk;
  logic       rst_n;
  logic       uart_rx_line;
  logic       uart_tx;
  logic [7:0] led_col;
  logic [8:0] led_row;

  word_t      prog [$];     // program being built
  logic [7:0] rx_q [$];     // bytes decoded from uart_tx
  logic [15:0] lfsr_state;
  int         errors;
  int         onehot_errs;
  int         tests_run;
  int         tests_failed;

  board_top #(
    .clks_per_bit(clks_per_bit), .stack_depth(8),
    .scan_period(64), .gap_on(4), .gap_off(8)
  ) dut_i (
    .sys_clk(sys_clk), .rst_n(rst_n), .uart_rx(uart_rx_line), .uart_tx(uart_tx),
    .led_col(led_col), .led_row(led_row)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  row_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n) $onehot0(led_row))
    else begin
      onehot_errs = onehot_errs + 1;
      $display("ERROR t=%0t led_row: got %b expected zero or one-hot", $time, led_row);
    end

  // uart_tx frame decoder, sampled mid-bit on the falling edge
  initial begin
    logic [7:0] data;
    forever begin
      @(negedge sys_clk);
      if (uart_tx === 1'b0) begin
        repeat (clks_per_bit / 2) @(negedge sys_clk);
        if (uart_tx !== 1'b0) begin
          errors = errors + 1;
          $display("start bit on uart_tx did not last half a bit at %0t", $time);
        end else begin
          for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge sys_clk);
            data[i] = uart_tx;  // lsb first
          end
          repeat (clks_per_bit) @(negedge sys_clk);
          if (uart_tx !== 1'b1) begin
            errors = errors + 1;
            $display("stop bit on uart_tx was low at %0t", $time);
          end
          rx_q.push_back(data);
        end
      end
    end
  end

  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [14:0] random_operand();
    logic [14:0] v;
    v = '0;
    for (int i = 0; i < 15; i++) v = {v[13:0], lfsr_bit()};
    if (v == 15'h7fff) v = 15'h7ffe;  // push of 0x7fff would encode as 0xffff
    return v;
  endfunction

  function automatic word_t push_word(input logic [14:0] imm);
    return {1'b1, imm};
  endfunction

  function automatic word_t op_word(input opcode_e opc, input addr_t addr);
    return {1'b0, opc, addr};
  endfunction

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic apply_reset();
    @(posedge sys_clk);
    #1;
    rst_n = 1'b0;
    uart_rx_line = 1'b1;
    repeat (8) @(posedge sys_clk);
    #1;
    rst_n = 1'b1;
    rx_q.delete();
  endtask

  // start, 8 data bits, stop, one idle bit
  task automatic send_byte(input logic [7:0] b, input bit check_idle);
    logic [10:0] frame;
    frame = {2'b11, b, 1'b0};
    @(posedge sys_clk);
    #1;
    for (int i = 0; i < 11; i++) begin
      uart_rx_line = frame[i];
      repeat (clks_per_bit) begin
        @(posedge sys_clk);
        #1;
      end
      if (check_idle) begin
        assert (uart_tx === 1'b1) else begin
          errors = errors + 1;
          $display("ERROR t=%0t uart_tx: got %b expected 1", $time, uart_tx);
        end
      end
    end
  endtask

  task automatic load_program();
    apply_reset();
    foreach (prog[i]) begin
      send_byte(prog[i][15:8], 1'b1);  // high byte first
      send_byte(prog[i][7:0], 1'b1);
    end
  endtask

  task automatic start_program();
    send_byte(end_marker[15:8], 1'b0);
    send_byte(end_marker[7:0], 1'b0);
  endtask

  task automatic expect_byte(input logic [7:0] exp);
    int n;
    logic [7:0] got;
    n = 0;
    while (rx_q.size() == 0 && n < byte_timeout) begin
      @(negedge sys_clk);
      n++;
    end
    if (rx_q.size() == 0) begin
      fail_timeout("a uart frame from the DUT");
    end else begin
      got = rx_q.pop_front();
      assert (got == exp) else begin
        errors = errors + 1;
        $display("ERROR t=%0t uart_tx byte: got %02h expected %02h", $time, got, exp);
      end
    end
  endtask

  task automatic wait_row(input logic [8:0] row);
    int n;
    n = 0;
    while (led_row !== row && n < row_timeout) begin
      @(negedge sys_clk);
      n++;
    end
    if (led_row !== row) fail_timeout("an led row to light up");
  endtask

  // rows 0 and 1 carry the last word written to memory
  task automatic verify_display(input word_t exp);
    wait_row(9'b000000001);
    assert (led_col == exp[15:8]) else begin
      errors = errors + 1;
      $display("ERROR t=%0t led_col row 0: got %02h expected %02h", $time, led_col, exp[15:8]);
    end
    wait_row(9'b000000010);
    assert (led_col == exp[7:0]) else begin
      errors = errors + 1;
      $display("ERROR t=%0t led_col row 1: got %02h expected %02h", $time, led_col, exp[7:0]);
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors + onehot_errs == errs_at_start) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAIL", tests_run, name);
    end
  endtask

  task automatic alu_test(input opcode_e opc, input string name, input bit idle_report);
    logic [14:0] a;
    logic [14:0] b;
    word_t       exp;
    int          start;
    a = random_operand();
    b = random_operand();
    case (opc)
      op_add:  exp = {1'b0, a} + {1'b0, b};
      op_sub:  exp = {1'b0, a} - {1'b0, b};  // second minus top
      default: exp = {1'b0, a & b};
    endcase
    prog.delete();
    prog.push_back(push_word(a));
    prog.push_back(push_word(b));
    prog.push_back(op_word(opc, 10'd0));
    prog.push_back(op_word(op_store, tx_addr));
    prog.push_back(op_word(op_halt, 10'd0));
    start = errors + onehot_errs;
    load_program();
    if (idle_report) begin
      assert (rx_q.size() == 0) else begin
        errors = errors + 1;
        $display("a uart frame appeared before the end marker at %0t", $time);
      end
      report_test("idle uart before run", start);
      start = errors + onehot_errs;
    end
    start_program();
    expect_byte(exp[7:0]);
    verify_display(exp);
    report_test(name, start);
  endtask

  task automatic load_store_test();
    logic [14:0] v;
    word_t       exp;
    int          start;
    v = random_operand();
    exp = {1'b0, v} + {1'b0, v};
    prog.delete();
    prog.push_back(push_word(v));
    prog.push_back(op_word(op_store, 10'h020));
    prog.push_back(op_word(op_load, 10'h020));
    prog.push_back(op_word(op_dup, 10'd0));
    prog.push_back(op_word(op_add, 10'd0));
    prog.push_back(op_word(op_store, tx_addr));
    prog.push_back(op_word(op_halt, 10'd0));
    start = errors + onehot_errs;
    load_program();
    start_program();
    expect_byte(exp[7:0]);
    verify_display(exp);
    report_test("store load dup add", start);
  endtask

  task automatic countdown_test();
    int base;
    int start;
    base = int'(prog_base);
    prog.delete();
    prog.push_back(push_word(15'd3));
    prog.push_back(op_word(op_dup, 10'd0));  // loop head at base + 1
    prog.push_back(op_word(op_store, tx_addr));
    for (int i = 0; i < countdown_pad; i++) begin
      prog.push_back(op_word(op_jmp, addr_t'(base + prog.size() + 1)));  // jump to next
    end
    prog.push_back(push_word(15'd1));
    prog.push_back(op_word(op_sub, 10'd0));
    prog.push_back(op_word(op_dup, 10'd0));
    prog.push_back(op_word(op_jz, addr_t'(base + prog.size() + 2)));
    prog.push_back(op_word(op_jmp, addr_t'(base + 1)));
    prog.push_back(op_word(op_halt, 10'd0));
    start = errors + onehot_errs;
    load_program();
    start_program();
    expect_byte(8'd3);
    expect_byte(8'd2);
    expect_byte(8'd1);
    repeat (quiet_window) @(negedge sys_clk);
    assert (rx_q.size() == 0) else begin
      errors = errors + 1;
      $display("an extra uart frame arrived after the countdown at %0t", $time);
    end
    verify_display(16'h0001);  // last store wrote 1
    report_test("countdown loop", start);
  endtask

  initial begin
    rst_n = 1'b0;
    uart_rx_line = 1'b1;
    lfsr_state = 16'd27;
    errors = 0;
    onehot_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    alu_test(op_add, "add", 1'b1);
    alu_test(op_sub, "sub", 1'b0);
    alu_test(op_and, "and", 1'b0);
    load_store_test();
    countdown_test();
    $display("tests run %0d, failed %0d, errors %0d",
             tests_run, tests_failed, errors + onehot_errs);
    if (tests_failed == 0 && errors + onehot_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* tb.f */
src/cpu_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/program_loader.sv
src/program_mem.sv
src/stack_cpu.sv
src/led_matrix.sv
src/board_top.sv
verification/board_tb.sv

/* Makefile */
# Verilator build and run of the board testbench

VERILATOR ?= verilator
TOP       ?= board_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
